//--- verilog/dotp_pkg.sv
// shared widths, vector types, enums and format constants for the fp8 dot-product unit and its testbench
package dotp_pkg;

  // ------------------------------------------------------------------
  // format geometry
  // ------------------------------------------------------------------
  localparam int FP8_EXP_W  = 5;   // e5m2
  localparam int FP8_MAN_W  = 2;
  localparam int FP8_BIAS   = 15;
  localparam int FP16_EXP_W = 5;   // ieee half
  localparam int FP16_MAN_W = 10;
  localparam int FP16_BIAS  = 15;

  // fixed-point accumulator, lsb weighs 2^ACC_LSB_EXP
  localparam int ACC_W       = 68;
  localparam int ACC_LSB_EXP = -32;
  localparam int EXP_W       = 7;  // unbiased exponent incl. sign

  localparam int PIPE_STAGES = 2;  // fixed latency

  // ------------------------------------------------------------------
  // plain vector types
  // ------------------------------------------------------------------
  typedef logic [FP8_EXP_W+FP8_MAN_W:0]   fp8_t;
  typedef logic [FP16_EXP_W+FP16_MAN_W:0] fp16_t;
  typedef logic [15:0]                    operand_t;  // two fp8 lanes or one fp16
  typedef logic [3:0]                     tag_t;
  typedef logic [2:0]                     status_t;   // {invalid, overflow, inexact}
  typedef logic signed [ACC_W-1:0]        acc_t;
  typedef logic signed [EXP_W-1:0]        exp_t;

  // ------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------
  typedef enum logic {
    OP_SDOTP,  // a0*b0 + a1*b1 + c
    OP_VSUM    // a0 + a1 + c
  } dotp_op_e;

  typedef enum logic {
    RM_RNE,
    RM_RTZ
  } roundmode_e;

  typedef enum logic [2:0] {
    CLS_ZERO,
    CLS_SUB,
    CLS_NORM,
    CLS_INF,
    CLS_NAN
  } fp_class_e;

  // special encodings
  localparam fp8_t  FP8_ONE   = 8'h3c;     // 0_01111_00
  localparam fp16_t FP16_QNAN = 16'h7e00;  // canonical nan
  localparam fp16_t FP16_INF  = 16'h7c00;
  localparam fp16_t FP16_MAX  = 16'h7bff;  // largest finite

endpackage

//--- verilog/fp_unpack.sv
// classifies one floating-point value and splits it into sign, unbiased exponent and significand
module fp_unpack #(
  parameter int ExpWidth = 5,
  parameter int ManWidth = 2
) (
  input  logic [ExpWidth+ManWidth:0] value_i,
  output logic                       sign_o,
  output dotp_pkg::exp_t             exp_o,
  output logic [ManWidth:0]          sig_o,    // hidden bit on top
  output dotp_pkg::fp_class_e        class_o
);

  localparam int Bias = 2**(ExpWidth-1) - 1;  // ieee bias of the exponent field

  logic [ExpWidth-1:0] exp_field;
  logic [ManWidth-1:0] man_field;
  logic                exp_zero, exp_ones, man_zero;

  assign {sign_o, exp_field, man_field} = value_i;

  assign exp_zero = (exp_field == '0);
  assign exp_ones = (exp_field == '1);
  assign man_zero = (man_field == '0);

  // subnormals and zero share the exponent of the smallest normal
  assign exp_o = exp_zero ? dotp_pkg::exp_t'(1 - Bias)
                          : dotp_pkg::exp_t'(int'(exp_field) - Bias);
  assign sig_o = {~exp_zero, man_field};  // hidden bit clear for subnormal

  always_comb begin
    if (exp_zero) begin
      class_o = man_zero ? dotp_pkg::CLS_ZERO : dotp_pkg::CLS_SUB;
    end else if (exp_ones) begin
      class_o = man_zero ? dotp_pkg::CLS_INF : dotp_pkg::CLS_NAN;
    end else begin
      class_o = dotp_pkg::CLS_NORM;
    end
  end

endmodule

//--- verilog/sdotp_accumulate.sv
// exact fp8 products plus fp16 addend on one fixed-point grid, with nan/inf special-case resolution
module sdotp_accumulate (
  input  logic                          a0_sign_i,
  input  dotp_pkg::exp_t                a0_exp_i,
  input  logic [dotp_pkg::FP8_MAN_W:0]  a0_sig_i,
  input  dotp_pkg::fp_class_e           a0_class_i,
  input  logic                          b0_sign_i,
  input  dotp_pkg::exp_t                b0_exp_i,
  input  logic [dotp_pkg::FP8_MAN_W:0]  b0_sig_i,
  input  dotp_pkg::fp_class_e           b0_class_i,
  input  logic                          a1_sign_i,
  input  dotp_pkg::exp_t                a1_exp_i,
  input  logic [dotp_pkg::FP8_MAN_W:0]  a1_sig_i,
  input  dotp_pkg::fp_class_e           a1_class_i,
  input  logic                          b1_sign_i,
  input  dotp_pkg::exp_t                b1_exp_i,
  input  logic [dotp_pkg::FP8_MAN_W:0]  b1_sig_i,
  input  dotp_pkg::fp_class_e           b1_class_i,
  input  logic                          c_sign_i,
  input  dotp_pkg::exp_t                c_exp_i,
  input  logic [dotp_pkg::FP16_MAN_W:0] c_sig_i,
  input  dotp_pkg::fp_class_e           c_class_i,
  output dotp_pkg::acc_t                sum_o,
  output logic                          special_o,
  output dotp_pkg::fp16_t               special_value_o,
  output logic                          invalid_o
);

  // signed term, mag scaled by 2^(shift + ACC_LSB_EXP)
  function automatic dotp_pkg::acc_t place(input logic neg,
                                           input logic [dotp_pkg::FP16_MAN_W:0] mag,
                                           input int shift);
    dotp_pkg::acc_t t;
    t = dotp_pkg::acc_t'(mag) <<< shift;
    return neg ? -t : t;
  endfunction

  // ------------------------------------------------------------------
  // exact terms
  // ------------------------------------------------------------------
  logic [2*dotp_pkg::FP8_MAN_W+1:0] prod0, prod1;  // 3x3 bit, exact
  int                               shift_p0, shift_p1, shift_c;

  assign prod0 = a0_sig_i * b0_sig_i;
  assign prod1 = a1_sig_i * b1_sig_i;

  // bit position of each term lsb inside the accumulator
  assign shift_p0 = int'(a0_exp_i) + int'(b0_exp_i) - 2*dotp_pkg::FP8_MAN_W
                    - dotp_pkg::ACC_LSB_EXP;
  assign shift_p1 = int'(a1_exp_i) + int'(b1_exp_i) - 2*dotp_pkg::FP8_MAN_W
                    - dotp_pkg::ACC_LSB_EXP;
  assign shift_c  = int'(c_exp_i) - dotp_pkg::FP16_MAN_W - dotp_pkg::ACC_LSB_EXP;

  assign sum_o = place(a0_sign_i ^ b0_sign_i, prod0, shift_p0)
               + place(a1_sign_i ^ b1_sign_i, prod1, shift_p1)
               + place(c_sign_i, c_sig_i, shift_c);

  // ------------------------------------------------------------------
  // special cases
  // ------------------------------------------------------------------
  logic any_nan;
  logic p0_inf, p1_inf, c_inf;
  logic inf_x_zero;       // inf * 0 in either product
  logic pos_inf, neg_inf;

  assign any_nan = (a0_class_i == dotp_pkg::CLS_NAN) || (b0_class_i == dotp_pkg::CLS_NAN)
                || (a1_class_i == dotp_pkg::CLS_NAN) || (b1_class_i == dotp_pkg::CLS_NAN)
                || (c_class_i  == dotp_pkg::CLS_NAN);

  assign p0_inf = (a0_class_i == dotp_pkg::CLS_INF) || (b0_class_i == dotp_pkg::CLS_INF);
  assign p1_inf = (a1_class_i == dotp_pkg::CLS_INF) || (b1_class_i == dotp_pkg::CLS_INF);
  assign c_inf  = (c_class_i == dotp_pkg::CLS_INF);

  assign inf_x_zero =
      (p0_inf && ((a0_class_i == dotp_pkg::CLS_ZERO) || (b0_class_i == dotp_pkg::CLS_ZERO)))
   || (p1_inf && ((a1_class_i == dotp_pkg::CLS_ZERO) || (b1_class_i == dotp_pkg::CLS_ZERO)));

  assign pos_inf = (p0_inf && !(a0_sign_i ^ b0_sign_i)) || (p1_inf && !(a1_sign_i ^ b1_sign_i))
                || (c_inf && !c_sign_i);
  assign neg_inf = (p0_inf && (a0_sign_i ^ b0_sign_i)) || (p1_inf && (a1_sign_i ^ b1_sign_i))
                || (c_inf && c_sign_i);

  always_comb begin
    special_o       = 1'b1;
    invalid_o       = 1'b0;
    special_value_o = dotp_pkg::FP16_QNAN;
    if (any_nan) begin
      // quiet nan, no flag
    end else if (inf_x_zero || (pos_inf && neg_inf)) begin
      invalid_o = 1'b1;
    end else if (pos_inf || neg_inf) begin
      special_value_o = {neg_inf, dotp_pkg::FP16_INF[14:0]};
    end else begin
      special_o = 1'b0;  // finite, sum_o is the result
    end
  end

  // every term, inf encodings included, lands fully inside the accumulator
  a_shift_range: assert final (
      shift_p0 >= 0 && shift_p0 + 2*dotp_pkg::FP8_MAN_W + 2 < dotp_pkg::ACC_W
   && shift_p1 >= 0 && shift_p1 + 2*dotp_pkg::FP8_MAN_W + 2 < dotp_pkg::ACC_W
   && shift_c  >= 0 && shift_c + dotp_pkg::FP16_MAN_W + 1 < dotp_pkg::ACC_W);

endmodule

//--- verilog/fp16_round_pack.sv
// normalises the fixed-point sum, rounds it once to fp16 and raises overflow/inexact flags
module fp16_round_pack (
  input  dotp_pkg::acc_t       sum_i,
  input  logic                 special_i,
  input  dotp_pkg::fp16_t      special_value_i,
  input  logic                 invalid_i,
  input  dotp_pkg::roundmode_e rnd_mode_i,
  output dotp_pkg::fp16_t      result_o,
  output dotp_pkg::status_t    status_o
);

  logic                                  sign;
  logic [dotp_pkg::ACC_W-1:0]            mag;       // |sum|
  int                                    lead;      // leading one position
  int                                    lsb;       // acc bit of result lsb
  logic [dotp_pkg::FP16_MAN_W:0]         sig;       // incl. hidden bit
  logic                                  guard, sticky, round_up;
  logic [dotp_pkg::EXP_W-1:0]            exp_field; // biased, wide for overflow
  logic [dotp_pkg::EXP_W+dotp_pkg::FP16_MAN_W-1:0] rounded;
  logic                                  overflow;

  // ------------------------------------------------------------------
  // normalise
  // ------------------------------------------------------------------
  always_comb begin
    sign = sum_i[dotp_pkg::ACC_W-1];
    mag  = sign ? -sum_i : sum_i;
    lead = 0;
    for (int i = 0; i < dotp_pkg::ACC_W; i++) begin
      if (mag[i]) lead = i;
    end
    // floor at the subnormal grid 2^-24
    lsb = 1 - dotp_pkg::FP16_BIAS - dotp_pkg::FP16_MAN_W - dotp_pkg::ACC_LSB_EXP;
    if (lead - dotp_pkg::FP16_MAN_W > lsb) begin
      lsb = lead - dotp_pkg::FP16_MAN_W;
    end
    sig    = mag[lsb +: dotp_pkg::FP16_MAN_W+1];
    guard  = mag[lsb-1];
    sticky = |(mag << (dotp_pkg::ACC_W + 1 - lsb));  // keeps bits below guard
    // hidden bit clear means subnormal, exponent field 0
    exp_field = sig[dotp_pkg::FP16_MAN_W]
              ? dotp_pkg::EXP_W'(lsb + dotp_pkg::ACC_LSB_EXP + dotp_pkg::FP16_MAN_W
                                 + dotp_pkg::FP16_BIAS)
              : '0;
  end

  // ------------------------------------------------------------------
  // round and pack
  // ------------------------------------------------------------------
  assign round_up = (rnd_mode_i == dotp_pkg::RM_RNE) && guard && (sticky || sig[0]);
  // mantissa carry ripples into the exponent, also subnormal -> normal
  assign rounded  = {exp_field, sig[dotp_pkg::FP16_MAN_W-1:0]} + round_up;
  assign overflow = rounded[dotp_pkg::EXP_W+dotp_pkg::FP16_MAN_W-1:dotp_pkg::FP16_MAN_W]
                    >= (2**dotp_pkg::FP16_EXP_W - 1);

  always_comb begin
    if (special_i) begin
      result_o = special_value_i;                   // nan / inf unchanged
      status_o = {invalid_i, 2'b00};
    end else if (overflow) begin
      result_o = (rnd_mode_i == dotp_pkg::RM_RTZ) ? {sign, dotp_pkg::FP16_MAX[14:0]}
                                                  : {sign, dotp_pkg::FP16_INF[14:0]};
      status_o = 3'b011;                            // overflow + inexact
    end else begin
      result_o = {sign, rounded[14:0]};             // exact zero comes out as +0
      status_o = {2'b00, guard | sticky};
    end
  end

endmodule

//--- verilog/sdotp_unit.sv
// two-stage fp8 dot-product pipeline with valid/ready handshake, flush and busy indication
module sdotp_unit (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  dotp_pkg::fp8_t       a0_i,
  input  dotp_pkg::fp8_t       b0_i,
  input  dotp_pkg::fp8_t       a1_i,
  input  dotp_pkg::fp8_t       b1_i,
  input  dotp_pkg::fp16_t      c_i,
  input  dotp_pkg::roundmode_e rnd_mode_i,
  input  dotp_pkg::tag_t       tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  output dotp_pkg::fp16_t      result_o,
  output dotp_pkg::status_t    status_o,
  output dotp_pkg::tag_t       tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  // ------------------------------------------------------------------
  // operand decode
  // ------------------------------------------------------------------
  dotp_pkg::fp8_t                lane      [4];  // a0, b0, a1, b1
  logic                          lane_sign [4];
  dotp_pkg::exp_t                lane_exp  [4];
  logic [dotp_pkg::FP8_MAN_W:0]  lane_sig  [4];
  dotp_pkg::fp_class_e           lane_cls  [4];
  logic                          c_sign;
  dotp_pkg::exp_t                c_exp;
  logic [dotp_pkg::FP16_MAN_W:0] c_sig;
  dotp_pkg::fp_class_e           c_cls;

  assign lane[0] = a0_i;
  assign lane[1] = b0_i;
  assign lane[2] = a1_i;
  assign lane[3] = b1_i;

  for (genvar i = 0; i < 4; i++) begin : gen_lane_unpack
    fp_unpack #(
      .ExpWidth ( dotp_pkg::FP8_EXP_W ),
      .ManWidth ( dotp_pkg::FP8_MAN_W )
    ) u_unpack (
      .value_i ( lane[i]      ),
      .sign_o  ( lane_sign[i] ),
      .exp_o   ( lane_exp[i]  ),
      .sig_o   ( lane_sig[i]  ),
      .class_o ( lane_cls[i]  )
    );
  end

  fp_unpack #(
    .ExpWidth ( dotp_pkg::FP16_EXP_W ),
    .ManWidth ( dotp_pkg::FP16_MAN_W )
  ) u_unpack_c (
    .value_i ( c_i    ),
    .sign_o  ( c_sign ),
    .exp_o   ( c_exp  ),
    .sig_o   ( c_sig  ),
    .class_o ( c_cls  )
  );

  // exact sum and specials, combinational
  dotp_pkg::acc_t  acc_sum;
  logic            acc_special, acc_invalid;
  dotp_pkg::fp16_t acc_special_value;

  sdotp_accumulate u_accumulate (
    .a0_sign_i (lane_sign[0]), .a0_exp_i (lane_exp[0]), .a0_sig_i (lane_sig[0]),
    .a0_class_i (lane_cls[0]),
    .b0_sign_i (lane_sign[1]), .b0_exp_i (lane_exp[1]), .b0_sig_i (lane_sig[1]),
    .b0_class_i (lane_cls[1]),
    .a1_sign_i (lane_sign[2]), .a1_exp_i (lane_exp[2]), .a1_sig_i (lane_sig[2]),
    .a1_class_i (lane_cls[2]),
    .b1_sign_i (lane_sign[3]), .b1_exp_i (lane_exp[3]), .b1_sig_i (lane_sig[3]),
    .b1_class_i (lane_cls[3]),
    .c_sign_i  (c_sign), .c_exp_i (c_exp), .c_sig_i (c_sig), .c_class_i (c_cls),
    .sum_o           ( acc_sum           ),
    .special_o       ( acc_special       ),
    .special_value_o ( acc_special_value ),
    .invalid_o       ( acc_invalid       )
  );

  // ------------------------------------------------------------------
  // pipeline control
  // ------------------------------------------------------------------
  logic s1_valid, s2_valid;
  logic advance;  // both stages move together

  assign advance     = ~s2_valid | out_ready_i;
  assign in_ready_o  = advance;
  assign out_valid_o = s2_valid;
  assign busy_o      = s1_valid | s2_valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (flush_i) begin  // drop everything in flight
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid_i;
      s2_valid <= s1_valid;
    end
  end

  // stage 1 payload
  dotp_pkg::acc_t       s1_sum;
  logic                 s1_special, s1_invalid;
  dotp_pkg::fp16_t      s1_special_value;
  dotp_pkg::roundmode_e s1_rnd;
  dotp_pkg::tag_t       s1_tag;

  always_ff @(posedge clk_i) begin
    if (advance && in_valid_i) begin
      s1_sum           <= acc_sum;
      s1_special       <= acc_special;
      s1_special_value <= acc_special_value;
      s1_invalid       <= acc_invalid;
      s1_rnd           <= rnd_mode_i;
      s1_tag           <= tag_i;
    end
  end

  // round on stage 1, register into stage 2
  dotp_pkg::fp16_t   rp_result;
  dotp_pkg::status_t rp_status;

  fp16_round_pack u_round_pack (
    .sum_i           ( s1_sum           ),
    .special_i       ( s1_special       ),
    .special_value_i ( s1_special_value ),
    .invalid_i       ( s1_invalid       ),
    .rnd_mode_i      ( s1_rnd           ),
    .result_o        ( rp_result        ),
    .status_o        ( rp_status        )
  );

  always_ff @(posedge clk_i) begin
    if (advance && s1_valid) begin  // held while stalled
      result_o <= rp_result;
      status_o <= rp_status;
      tag_o    <= s1_tag;
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));

  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_o);

endmodule

//--- verilog/dotp_wrapper.sv
// top level of the expanding dot-product unit; maps packed operands onto fp8 lanes and fp16 addend
module dotp_wrapper (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // operation
  input  dotp_pkg::operand_t [2:0]   operands_i,  // a lanes, b lanes, addend c
  input  dotp_pkg::dotp_op_e         op_i,
  input  logic                       op_mod_i,    // subtract addend
  input  dotp_pkg::roundmode_e       rnd_mode_i,
  input  dotp_pkg::tag_t             tag_i,
  // input handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  // result
  output dotp_pkg::fp16_t            result_o,
  output dotp_pkg::status_t          status_o,
  output dotp_pkg::tag_t             tag_o,
  // output handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o
);

  // ------------------------------------------------------------------
  // lane extraction
  // ------------------------------------------------------------------
  dotp_pkg::fp8_t  op_a0, op_b0, op_a1, op_b1;
  dotp_pkg::fp16_t op_c;
  logic            is_vsum;

  assign is_vsum = (op_i == dotp_pkg::OP_VSUM);

  assign op_a0 = operands_i[0][7:0];   // lane 0 in low byte
  assign op_a1 = operands_i[0][15:8];
  // vsum multiplies every a lane by one, unit only sees a dot product
  assign op_b0 = is_vsum ? dotp_pkg::FP8_ONE : operands_i[1][7:0];
  assign op_b1 = is_vsum ? dotp_pkg::FP8_ONE : operands_i[1][15:8];
  assign op_c  = {operands_i[2][15] ^ op_mod_i, operands_i[2][14:0]};  // sign flip for -c

  sdotp_unit u_sdotp_unit (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .a0_i        ( op_a0       ),
    .b0_i        ( op_b0       ),
    .a1_i        ( op_a1       ),
    .b1_i        ( op_b1       ),
    .c_i         ( op_c        ),
    .rnd_mode_i  ( rnd_mode_i  ),
    .tag_i       ( tag_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  // operation select must be decodable whenever an op is offered
  a_op_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i |-> !$isunknown(op_i));

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and reset source, period 8, reset low for the first two rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 units per cycle
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 arst_n_o = 1'b1;  // release just after the edge
  end

endmodule

//--- verification/tb_checker.sv
// testbench monitor; compares every accepted dut output with the expectation queue and tracks busy
module tb_checker (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              in_valid_i,
  input  logic              in_ready_i,
  input  logic              flush_i,
  input  logic              out_valid_i,
  input  logic              out_ready_i,
  input  logic              busy_i,
  input  dotp_pkg::fp16_t   result_i,
  input  dotp_pkg::status_t status_i,
  input  dotp_pkg::tag_t    tag_i,
  output int                checked_o,
  output int                errors_o
);

  int          inflight;  // ops accepted but neither delivered nor flushed
  logic [34:0] head;      // {index, group, result, status, tag}
  string       name;

  function automatic string test_name(input logic [3:0] grp, input logic [7:0] idx);
    string s;
    case (grp)
      4'd1:    s = "sdotp_rne";
      4'd2:    s = "vsum_sub";
      4'd3:    s = "rtz_overflow";
      4'd4:    s = "special";
      4'd5:    s = "order";
      4'd6:    s = "flush";
      default: s = "unknown";
    endcase
    return $sformatf("%s_%0d", s, idx);
  endfunction

  task automatic check_field(input string tname, input string field,
                             input logic [15:0] expected, input logic [15:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s expected %h actual %h", tname, field, expected, actual);
      errors_o++;
    end
  endtask

  // ------------------------------------------------------------------
  // sampled mid-cycle, values here are the ones the next edge takes
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      inflight  = 0;
      checked_o = 0;
      errors_o  = 0;
    end else begin
      if (busy_i !== (inflight != 0)) begin
        $display("busy_o is %b while %0d operations are in flight", busy_i, inflight);
        errors_o++;
      end
      if (out_valid_i && out_ready_i) begin
        if (tb_dotp.exp_q.size() == 0) begin
          $display("result with tag %h came out while no operation was expected", tag_i);
          errors_o++;
        end else begin
          head = tb_dotp.exp_q.pop_front();
          name = test_name(head[26:23], head[34:27]);
          checked_o++;
          check_field(name, "result", head[22:7], result_i);
          check_field(name, "status", 16'(head[6:4]), 16'(status_i));
          check_field(name, "tag", 16'(head[3:0]), 16'(tag_i));
        end
      end
      if (flush_i) begin
        inflight = 0;  // flush drops both stages
      end else begin
        inflight = inflight + int'(in_valid_i && in_ready_i) - int'(out_valid_i && out_ready_i);
      end
    end
  end

endmodule

//--- verification/tb_dotp.sv
// testbench top; plays the vector file into the dot-product unit with random output stalls
module tb_dotp;

  localparam int MAX_VEC      = 64;
  localparam int RESET_CYCLES = 2;

  logic                     clk, arst_n;
  dotp_pkg::operand_t [2:0] operands;
  dotp_pkg::dotp_op_e       op;
  logic                     op_mod;
  dotp_pkg::roundmode_e     rnd_mode;
  dotp_pkg::tag_t           tag, out_tag;
  logic                     in_valid, in_ready, flush, out_valid, out_ready, busy;
  dotp_pkg::fp16_t          result;
  dotp_pkg::status_t        status;

  logic [91:0] vec_mem [MAX_VEC];  // one line of the vector file each
  logic [34:0] exp_q [$];          // {index, group, result, status, tag}
  logic [31:0] rnd_state;
  logic        hold_out;           // forces out_ready low around the flush
  int          n_vec, idx, cycle_cnt, cycle_limit, tb_errors, checked, chk_errors;

  tb_clock_gen u_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

  dotp_wrapper dut_i (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .operands_i  ( operands  ),
    .op_i        ( op        ),
    .op_mod_i    ( op_mod    ),
    .rnd_mode_i  ( rnd_mode  ),
    .tag_i       ( tag       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( out_tag   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  tb_checker u_checker (
    .clk_i (clk), .arst_n_i (arst_n), .in_valid_i (in_valid), .in_ready_i (in_ready),
    .flush_i (flush), .out_valid_i (out_valid), .out_ready_i (out_ready), .busy_i (busy),
    .result_i (result), .status_i (status), .tag_i (out_tag),
    .checked_o (checked), .errors_o (chk_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_counts();
    $display("results checked %0d, mismatches and protocol errors %0d, run errors %0d",
             checked, chk_errors, tb_errors);
  endtask

  // ------------------------------------------------------------------
  // stimulus, always entered and left 1 unit after a rising edge
  // ------------------------------------------------------------------
  task automatic send(input int i);
    logic [91:0] v;
    logic        accepted;
    v           = vec_mem[i];
    op          = dotp_pkg::dotp_op_e'(v[80]);
    op_mod      = v[76];
    rnd_mode    = dotp_pkg::roundmode_e'(v[72]);
    operands[0] = v[71:56];  // a lanes
    operands[1] = v[55:40];  // b lanes
    operands[2] = v[39:24];  // addend
    tag         = v[23:20];
    in_valid    = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (in_ready) begin  // transfer on the coming edge
        accepted = 1'b1;
        exp_q.push_back({8'(i), v[91:88], v[19:4], v[2:0], v[23:20]});
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (busy);
  endtask

  // two victims in flight, then one flush cycle
  task automatic flush_pair(input int i);
    wait_idle();
    hold_out = 1'b1;
    @(posedge clk);
    #1;
    send(i);
    send(i + 1);
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    void'(exp_q.pop_back());  // flushed pair never arrives
    void'(exp_q.pop_back());
    @(negedge clk);
    hold_out = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // random back-pressure, low about one cycle in four
  always @(posedge clk) begin
    #1;
    rnd_state = xorshift32(rnd_state);
    out_ready = hold_out ? 1'b0 : (rnd_state[1:0] != 2'b00);
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      tb_errors++;
      report_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    operands  = '0;
    op        = dotp_pkg::OP_SDOTP;
    op_mod    = 1'b0;
    rnd_mode  = dotp_pkg::RM_RNE;
    tag       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    hold_out  = 1'b0;
    rnd_state = 32'hb0420990;
    tb_errors = 0;
    cycle_cnt = 0;
    n_vec     = 0;
    $readmemh("verification/dotp_vectors.txt", vec_mem);
    while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec])) n_vec++;
    if (n_vec == 0) begin
      $display("no vectors could be read from the vector file");
      tb_errors++;
    end
    cycle_limit = 20 * n_vec + dotp_pkg::PIPE_STAGES + RESET_CYCLES;

    wait (arst_n === 1'b1);
    @(posedge clk);
    #1;
    idx = 0;
    while (idx < n_vec) begin
      if (vec_mem[idx][84] && idx + 1 < n_vec) begin
        flush_pair(idx);
        idx += 2;
      end else begin
        send(idx);
        idx++;
      end
    end

    wait_idle();  // last result taken
    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out of the DUT", exp_q.size());
      tb_errors++;
    end
    report_counts();
    if (tb_errors + chk_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/dotp_pkg.sv
verilog/fp_unpack.sv
verilog/sdotp_accumulate.sv
verilog/fp16_round_pack.sv
verilog/sdotp_unit.sv
verilog/dotp_wrapper.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_dotp.sv

//--- verification/dotp_vectors.txt
// group_flush_op_mod_rm_a_b_c_tag_result_status, hex; a, b = {lane1, lane0} e5m2, c fp16
// group 1 sdotp 2 vsum/sub 3 rtz/overflow 4 special 5 order 6 flush; status = {inv, ovf, inx}
1_0_0_0_0_3e3c_4040_3c00_1_4600_0
1_0_0_0_0_0001_003c_0000_2_0100_0
1_0_0_0_0_013d_3c3d_3c00_3_4120_1
1_0_0_0_0_bc3c_3c40_bc00_4_0000_0
2_0_1_0_0_403e_7f7f_3800_5_4400_0
2_0_1_1_0_3c44_0000_4000_6_4200_0
2_0_1_0_0_013c_0000_6800_7_6801_1
2_0_1_1_0_3c3c_0000_4200_8_bc00_0
3_0_0_0_0_007b_0040_0000_9_7c00_3
3_0_0_0_1_007b_0040_0000_a_7bff_3
3_0_0_0_0_004c_003c_7bff_b_7c00_3
3_0_0_0_1_004c_003c_7bff_c_7bff_1
3_0_0_0_0_003c_003c_6801_d_6802_1
3_0_0_0_1_003c_003c_6801_e_6801_1
3_0_0_0_1_00bc_003c_e801_f_e801_1
4_0_0_0_0_007d_003c_0000_0_7e00_0
4_0_0_0_0_007c_0000_7e00_1_7e00_0
4_0_0_0_0_007c_0000_0000_2_7e00_4
4_0_0_0_0_007c_003c_fc00_3_7e00_4
4_0_0_0_0_fc00_4000_0000_4_fc00_0
5_0_0_0_0_4040_4040_0000_5_4800_0
6_1_0_0_0_3c3c_3c3c_3c00_6_4200_0
6_1_0_0_0_4040_3c3c_0000_7_4400_0
6_0_0_0_0_3e3e_4040_0000_8_4600_0
6_0_1_0_0_3c3c_0000_3c00_9_4200_0
